// File: verilog/exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath and address width
`define EXU_XLEN 32

// architectural integer registers, x0 included
`define EXU_REG_NUM 32

// register index width
`define EXU_REG_AW 5

`endif

// File: verilog/exu_pkg.sv
`include "exu_cfg.svh"

package exu_pkg;

	typedef enum logic [3:0] {
		ALU_NONE = 4'd0,
		ALU_ADD  = 4'd1,
		ALU_SUB  = 4'd2,
		ALU_SLL  = 4'd3,
		ALU_SLT  = 4'd4,
		ALU_SLTU = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_SRL  = 4'd7,
		ALU_SRA  = 4'd8,
		ALU_OR   = 4'd9,
		ALU_AND  = 4'd10,
		ALU_PC   = 4'd11 // pc + 4, link value
	} alu_opt_e;

	typedef enum logic [2:0] {
		SRC_RS1_IMM  = 3'd0,
		SRC_RS1_RS2  = 3'd1,
		SRC_PC_IMM   = 3'd2, // auipc
		SRC_ZERO_IMM = 3'd3  // lui
	} src_sel_e;

	typedef enum logic [2:0] {
		CLS_NONE   = 3'd0,
		CLS_ALU    = 3'd1,
		CLS_BRANCH = 3'd2,
		CLS_JAL    = 3'd3,
		CLS_JALR   = 3'd4,
		CLS_LOAD   = 3'd5,
		CLS_STORE  = 3'd6
	} inst_cls_e;

	// rv32i base opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_FENCE  = 7'b0001111;
	localparam logic [6:0] OPC_SYS    = 7'b1110011;

endpackage

// File: verilog/exu_id_opt.sv
`include "exu_cfg.svh"

module exu_id_opt (
	input  logic [6:0]          opcode,
	input  logic [2:0]          funct3,
	input  logic                funct7,  // inst[30] only
	output exu_pkg::alu_opt_e   alu_opt,
	output exu_pkg::src_sel_e   src_sel,
	output exu_pkg::inst_cls_e  inst_cls
);
	import exu_pkg::*;

	always_comb begin
		alu_opt  = ALU_NONE;
		src_sel  = SRC_RS1_IMM;
		inst_cls = CLS_NONE;
		casez (opcode)
			OPC_LUI: begin
				alu_opt  = ALU_ADD; // 0 + imm
				src_sel  = SRC_ZERO_IMM;
				inst_cls = CLS_ALU;
			end
			OPC_AUIPC: begin
				alu_opt  = ALU_ADD;
				src_sel  = SRC_PC_IMM;
				inst_cls = CLS_ALU;
			end
			OPC_JAL: begin
				alu_opt  = ALU_PC; // link value
				src_sel  = SRC_PC_IMM;
				inst_cls = CLS_JAL;
			end
			OPC_JALR: begin
				alu_opt  = ALU_PC;
				inst_cls = CLS_JALR;
			end
			OPC_BRANCH: begin
				src_sel  = SRC_RS1_RS2;
				inst_cls = CLS_BRANCH;
				case (funct3)
					3'b000, 3'b001: alu_opt = ALU_SUB;  // beq, bne
					3'b100, 3'b101: alu_opt = ALU_SLT;  // blt, bge
					3'b110, 3'b111: alu_opt = ALU_SLTU; // bltu, bgeu
					default:        inst_cls = CLS_NONE; // reserved funct3
				endcase
			end
			OPC_LOAD:  inst_cls = CLS_LOAD;  // no data memory here
			OPC_STORE: inst_cls = CLS_STORE;
			OPC_OP_IMM: begin
				inst_cls = CLS_ALU;
				case (funct3)
					3'b000: alu_opt = ALU_ADD;  // addi
					3'b001: alu_opt = ALU_SLL;  // slli
					3'b010: alu_opt = ALU_SLT;  // slti
					3'b011: alu_opt = ALU_SLTU; // sltiu
					3'b100: alu_opt = ALU_XOR;
					3'b101: alu_opt = funct7 ? ALU_SRA : ALU_SRL;
					3'b110: alu_opt = ALU_OR;
					default: alu_opt = ALU_AND;
				endcase
			end
			OPC_OP: begin
				src_sel  = SRC_RS1_RS2;
				inst_cls = CLS_ALU;
				case (funct3)
					3'b000: alu_opt = funct7 ? ALU_SUB : ALU_ADD;
					3'b001: alu_opt = ALU_SLL;
					3'b010: alu_opt = ALU_SLT;
					3'b011: alu_opt = ALU_SLTU;
					3'b100: alu_opt = ALU_XOR;
					3'b101: alu_opt = funct7 ? ALU_SRA : ALU_SRL;
					3'b110: alu_opt = ALU_OR;
					default: alu_opt = ALU_AND;
				endcase
			end
			// fence, system and unknown opcodes are no-ops
			default: begin
				alu_opt  = ALU_NONE;
				inst_cls = CLS_NONE;
			end
		endcase
	end

endmodule

// File: verilog/exu_imm_gen.sv
`include "exu_cfg.svh"

module exu_imm_gen (
	input  logic [31:0]           inst,
	output logic [`EXU_XLEN-1:0]  imm
);
	import exu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       sign;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign sign   = inst[31];

	always_comb begin
		case (opcode)
			OPC_OP_IMM: begin
				if (funct3 == 3'b001 || funct3 == 3'b101)
					imm = {27'b0, inst[24:20]}; // shamt
				else
					imm = {{20{sign}}, inst[31:20]};
			end
			OPC_JALR,
			OPC_LOAD: begin
				imm = {{20{sign}}, inst[31:20]}; // i-type
			end
			OPC_STORE: begin
				imm = {{20{sign}}, inst[31:25], inst[11:7]};
			end
			OPC_BRANCH: begin
				imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			OPC_LUI,
			OPC_AUIPC: begin
				imm = {inst[31:12], 12'b0};
			end
			OPC_JAL: begin
				imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: begin
				imm = '0; // r-type, fence, system, unknown
			end
		endcase
	end

endmodule

// File: verilog/exu_dec_stage.sv
`include "exu_cfg.svh"

module exu_dec_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    inst_valid,
	input  logic [31:0]             inst,
	input  logic [`EXU_XLEN-1:0]    pc,
	output logic                    s1_valid,
	output logic [`EXU_XLEN-1:0]    s1_pc,
	output logic [2:0]              funct3,
	output logic [`EXU_REG_AW-1:0]  rs1,
	output logic [`EXU_REG_AW-1:0]  rs2,
	output logic [`EXU_REG_AW-1:0]  rd,
	output logic [`EXU_XLEN-1:0]    s1_imm,
	output exu_pkg::alu_opt_e       alu_opt,
	output exu_pkg::src_sel_e       src_sel,
	output exu_pkg::inst_cls_e      inst_cls
);
	import exu_pkg::*;

	logic [31:0] inst_q; // held instruction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= inst_valid; // one cycle per strobe
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			inst_q <= '0;
			s1_pc  <= '0;
		end else if (inst_valid) begin
			inst_q <= inst;
			s1_pc  <= pc;
		end
	end

	assign funct3 = inst_q[14:12];
	assign rs1    = inst_q[19:15];
	assign rs2    = inst_q[24:20];
	assign rd     = inst_q[11:7];

	exu_id_opt id_opt_i (
		.opcode   (inst_q[6:0]),
		.funct3   (inst_q[14:12]),
		.funct7   (inst_q[30]),
		.alu_opt  (alu_opt),
		.src_sel  (src_sel),
		.inst_cls (inst_cls)
	);

	exu_imm_gen imm_gen_i (
		.inst (inst_q),
		.imm  (s1_imm)
	);

endmodule

// File: verilog/exu_regfile.sv
`include "exu_cfg.svh"

module exu_regfile (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [`EXU_REG_AW-1:0]  rs1,
	input  logic [`EXU_REG_AW-1:0]  rs2,
	input  logic                    rf_we,
	input  logic [`EXU_REG_AW-1:0]  rf_waddr,
	input  logic [`EXU_XLEN-1:0]    rf_wdata,
	output logic [`EXU_XLEN-1:0]    rs1_data,
	output logic [`EXU_XLEN-1:0]    rs2_data
);

	// x0 has no storage
	logic [`EXU_XLEN-1:0] regs [1:`EXU_REG_NUM-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `EXU_REG_NUM; i++)
				regs[i] <= '0;
		end else if (rf_we && rf_waddr != '0) begin
			regs[rf_waddr] <= rf_wdata;
		end
	end

	// async read, x0 reads zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: verilog/exu_alu.sv
`include "exu_cfg.svh"

module exu_alu (
	input  exu_pkg::alu_opt_e       alu_opt,
	input  exu_pkg::src_sel_e       src_sel,
	input  logic [`EXU_XLEN-1:0]    s1_pc,
	input  logic [`EXU_XLEN-1:0]    rs1_data,
	input  logic [`EXU_XLEN-1:0]    rs2_data,
	input  logic [`EXU_XLEN-1:0]    s1_imm,
	output logic [`EXU_XLEN-1:0]    alu_res
);
	import exu_pkg::*;

	localparam int SHW = $clog2(`EXU_XLEN);

	logic [`EXU_XLEN-1:0] op_a;
	logic [`EXU_XLEN-1:0] op_b;
	logic [SHW-1:0]       shamt;

	// operand pair
	always_comb begin
		case (src_sel)
			SRC_RS1_IMM:  begin op_a = rs1_data; op_b = s1_imm;   end
			SRC_RS1_RS2:  begin op_a = rs1_data; op_b = rs2_data; end
			SRC_PC_IMM:   begin op_a = s1_pc;    op_b = s1_imm;   end
			SRC_ZERO_IMM: begin op_a = '0;       op_b = s1_imm;   end
			default:      begin op_a = '0;       op_b = '0;       end
		endcase
	end

	assign shamt = op_b[SHW-1:0];

	always_comb begin
		case (alu_opt)
			ALU_ADD:  alu_res = op_a + op_b;
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << shamt;
			ALU_SLT:  alu_res = {{(`EXU_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {{(`EXU_XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> shamt;
			ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			ALU_PC:   alu_res = s1_pc + `EXU_XLEN'd4; // link address
			default:  alu_res = '0;
		endcase
	end

endmodule

// File: verilog/exu_wb.sv
`include "exu_cfg.svh"

module exu_wb (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    s1_valid,
	input  exu_pkg::inst_cls_e      inst_cls,
	input  logic [2:0]              funct3,
	input  logic [`EXU_REG_AW-1:0]  rd,
	input  logic [`EXU_XLEN-1:0]    alu_res,
	input  logic [`EXU_XLEN-1:0]    s1_pc,
	input  logic [`EXU_XLEN-1:0]    s1_imm,
	input  logic [`EXU_XLEN-1:0]    rs1_data,
	output logic                    rf_we,
	output logic [`EXU_REG_AW-1:0]  rf_waddr,
	output logic [`EXU_XLEN-1:0]    rf_wdata,
	output logic                    wb_valid,
	output logic [`EXU_REG_AW-1:0]  wb_rd,
	output logic [`EXU_XLEN-1:0]    wb_data,
	output logic                    jump_valid,
	output logic                    jump_taken,
	output logic [`EXU_XLEN-1:0]    jump_target
);
	import exu_pkg::*;

	logic                 is_jump;
	logic                 br_cond;
	logic                 taken;
	logic [`EXU_XLEN-1:0] target;

	assign is_jump = s1_valid &&
		(inst_cls == CLS_BRANCH || inst_cls == CLS_JAL || inst_cls == CLS_JALR);

	assign rf_we = s1_valid && rd != '0 &&
		(inst_cls == CLS_ALU || inst_cls == CLS_JAL || inst_cls == CLS_JALR);
	assign rf_waddr = rd;
	assign rf_wdata = alu_res;

	always_comb begin
		case (funct3)
			3'b000:         br_cond = (alu_res == '0); // beq
			3'b001:         br_cond = (alu_res != '0); // bne
			3'b100, 3'b110: br_cond = alu_res[0];      // blt, bltu
			3'b101, 3'b111: br_cond = ~alu_res[0];     // bge, bgeu
			default:        br_cond = 1'b0;
		endcase
	end

	assign taken  = (inst_cls == CLS_BRANCH) ? br_cond : 1'b1;
	assign target = (inst_cls == CLS_JALR) ? ((rs1_data + s1_imm) & ~`EXU_XLEN'd1)
		: (s1_pc + s1_imm);

	// outputs are zero outside their pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid    <= 1'b0;
			wb_rd       <= '0;
			wb_data     <= '0;
			jump_valid  <= 1'b0;
			jump_taken  <= 1'b0;
			jump_target <= '0;
		end else begin
			wb_valid    <= rf_we;
			wb_rd       <= rf_we ? rd : '0;
			wb_data     <= rf_we ? alu_res : '0;
			jump_valid  <= is_jump;
			jump_taken  <= is_jump && taken;
			jump_target <= is_jump ? target : '0;
		end
	end

endmodule

// File: verilog/exu_top.sv
`include "exu_cfg.svh"

module exu_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    inst_valid,
	input  logic [31:0]             inst,
	input  logic [`EXU_XLEN-1:0]    pc,
	output logic                    wb_valid,
	output logic [`EXU_REG_AW-1:0]  wb_rd,
	output logic [`EXU_XLEN-1:0]    wb_data,
	output logic                    jump_valid,
	output logic                    jump_taken,
	output logic [`EXU_XLEN-1:0]    jump_target
);
	import exu_pkg::*;

	// decode stage outputs
	logic                   s1_valid;
	logic [`EXU_XLEN-1:0]   s1_pc;
	logic [2:0]             funct3;
	logic [`EXU_REG_AW-1:0] rs1;
	logic [`EXU_REG_AW-1:0] rs2;
	logic [`EXU_REG_AW-1:0] rd;
	logic [`EXU_XLEN-1:0]   s1_imm;
	alu_opt_e               alu_opt;
	src_sel_e               src_sel;
	inst_cls_e              inst_cls;

	logic [`EXU_XLEN-1:0]   rs1_data;
	logic [`EXU_XLEN-1:0]   rs2_data;
	logic [`EXU_XLEN-1:0]   alu_res;

	// write port, driven by wb
	logic                   rf_we;
	logic [`EXU_REG_AW-1:0] rf_waddr;
	logic [`EXU_XLEN-1:0]   rf_wdata;

	exu_dec_stage dec_i (
		.clk (clk), .arst_n (arst_n),
		.inst_valid (inst_valid), .inst (inst), .pc (pc),
		.s1_valid (s1_valid), .s1_pc (s1_pc), .funct3 (funct3),
		.rs1 (rs1), .rs2 (rs2), .rd (rd), .s1_imm (s1_imm),
		.alu_opt (alu_opt), .src_sel (src_sel), .inst_cls (inst_cls)
	);

	exu_regfile rf_i (
		.clk (clk), .arst_n (arst_n), .rs1 (rs1), .rs2 (rs2),
		.rf_we (rf_we), .rf_waddr (rf_waddr), .rf_wdata (rf_wdata),
		.rs1_data (rs1_data), .rs2_data (rs2_data)
	);

	exu_alu alu_i (
		.alu_opt (alu_opt), .src_sel (src_sel), .s1_pc (s1_pc),
		.rs1_data (rs1_data), .rs2_data (rs2_data), .s1_imm (s1_imm),
		.alu_res (alu_res)
	);

	exu_wb wb_i (
		.clk (clk), .arst_n (arst_n), .s1_valid (s1_valid), .inst_cls (inst_cls),
		.funct3 (funct3), .rd (rd), .alu_res (alu_res), .s1_pc (s1_pc),
		.s1_imm (s1_imm), .rs1_data (rs1_data),
		.rf_we (rf_we), .rf_waddr (rf_waddr), .rf_wdata (rf_wdata),
		.wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data),
		.jump_valid (jump_valid), .jump_taken (jump_taken), .jump_target (jump_target)
	);

endmodule

// File: dv/exu_checker.sv
`include "exu_cfg.svh"

module exu_checker (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    inst_valid,
	input  logic [31:0]             inst,
	input  logic [`EXU_XLEN-1:0]    pc,
	input  logic                    wb_valid,
	input  logic [`EXU_REG_AW-1:0]  wb_rd,
	input  logic [`EXU_XLEN-1:0]    wb_data,
	input  logic                    jump_valid,
	input  logic                    jump_taken,
	input  logic [`EXU_XLEN-1:0]    jump_target,
	output int                      err_cnt,
	output int                      strobe_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	import exu_pkg::*;

	typedef logic [`EXU_XLEN-1:0] word_t;

	// all DUT outputs of one cycle
	typedef struct packed {
		logic                   wb_valid;
		logic [`EXU_REG_AW-1:0] wb_rd;
		word_t                  wb_data;
		logic                   jump_valid;
		logic                   jump_taken;
		word_t                  jump_target;
	} outs_t;

	word_t model_rf [0:`EXU_REG_NUM-1]; // x0 is never written
	outs_t exp_q [$];                   // two deep, one entry per edge

	// rv32i integer operation, alt selects sub and sra
	function automatic word_t int_op(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return word_t'($signed(a) < $signed(b));
			3'b011: return word_t'(a < b);
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $unsigned($signed(a) >>> b[4:0]);
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic outs_t model_step(input logic [31:0] ins, input word_t ipc);
		outs_t e;
		logic  wr;
		word_t res;
		word_t a;
		word_t b;
		word_t imm_i;
		word_t imm_b;
		word_t imm_j;
		word_t imm_u;
		e     = '0;
		wr    = 1'b0;
		res   = '0;
		a     = model_rf[ins[19:15]];
		b     = model_rf[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		imm_u = {ins[31:12], 12'h000};
		case (ins[6:0])
			OPC_LUI: begin
				wr  = 1'b1;
				res = imm_u;
			end
			OPC_AUIPC: begin
				wr  = 1'b1;
				res = ipc + imm_u;
			end
			OPC_JAL, OPC_JALR: begin
				wr            = 1'b1;
				res           = ipc + 32'd4; // link
				e.jump_valid  = 1'b1;
				e.jump_taken  = 1'b1;
				e.jump_target = (ins[6:0] == OPC_JAL) ? ipc + imm_j : (a + imm_i) & ~32'd1;
			end
			OPC_BRANCH: begin
				e.jump_valid  = ins[14] || !ins[13]; // funct3 010 and 011 are reserved
				e.jump_target = e.jump_valid ? ipc + imm_b : '0;
				case (ins[14:12])
					3'b000:  e.jump_taken = (a == b);
					3'b001:  e.jump_taken = (a != b);
					3'b100:  e.jump_taken = ($signed(a) < $signed(b));
					3'b101:  e.jump_taken = ($signed(a) >= $signed(b));
					3'b110:  e.jump_taken = (a < b);
					3'b111:  e.jump_taken = (a >= b);
					default: e.jump_taken = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				wr  = 1'b1;
				res = int_op(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
			end
			OPC_OP: begin
				wr  = 1'b1;
				res = int_op(ins[14:12], ins[30], a, b);
			end
			default: ; // load, store, fence, system, unknown
		endcase
		if (wr && ins[11:7] != '0) begin
			e.wb_valid = 1'b1;
			e.wb_rd    = ins[11:7];
			e.wb_data  = res;
		end
		return e;
	endfunction

	task automatic check_outs(input outs_t got, input outs_t want);
		if (got !== want) begin
			err_cnt++;
			$display("** Error @ %0t: outputs differ, expected wb %b x%0d %h jump %b %b %h",
				$time, want.wb_valid, want.wb_rd, want.wb_data,
				want.jump_valid, want.jump_taken, want.jump_target);
			$display("   got wb %b x%0d %h jump %b %b %h",
				got.wb_valid, got.wb_rd, got.wb_data,
				got.jump_valid, got.jump_taken, got.jump_target);
		end
	endtask

	always @(posedge clk) begin
		outs_t got;
		outs_t want;
		outs_t nxt;
		got = {wb_valid, wb_rd, wb_data, jump_valid, jump_taken, jump_target};
		if (!arst_n) begin
			want       = '0; // outputs held at zero in reset
			err_cnt    = 0;
			strobe_cnt = 0;
			for (int i = 0; i < `EXU_REG_NUM; i++)
				model_rf[i] = '0;
			exp_q.delete();
			exp_q.push_back('0);
			exp_q.push_back('0);
		end else begin
			want = exp_q.pop_front();
			nxt  = '0; // idle cycle, no pulse
			if (inst_valid) begin
				nxt = model_step(inst, pc);
				if (nxt.wb_valid)
					model_rf[nxt.wb_rd] = nxt.wb_data;
				strobe_cnt++;
			end
			exp_q.push_back(nxt);
		end
		check_outs(got, want);
	end

endmodule

// File: dv/exu_tb.sv
`include "exu_cfg.svh"

module exu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import exu_pkg::*;

	localparam int N_INST     = 2000;
	localparam int SEED       = 33085;
	localparam int CLK_NS     = 10;
	localparam int TIMEOUT_NS = N_INST * 3 * CLK_NS + 1000;

	logic                   clk;
	logic                   arst_n;
	logic                   inst_valid;
	logic [31:0]            inst;
	logic [`EXU_XLEN-1:0]   pc;
	logic                   wb_valid;
	logic [`EXU_REG_AW-1:0] wb_rd;
	logic [`EXU_XLEN-1:0]   wb_data;
	logic                   jump_valid;
	logic                   jump_taken;
	logic [`EXU_XLEN-1:0]   jump_target;
	int                     err_cnt;
	int                     strobe_cnt;
	int                     sent;

	exu_top dut_i (
		.clk (clk), .arst_n (arst_n),
		.inst_valid (inst_valid), .inst (inst), .pc (pc),
		.wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data),
		.jump_valid (jump_valid), .jump_taken (jump_taken), .jump_target (jump_target)
	);

	exu_checker chk_i (
		.clk (clk), .arst_n (arst_n),
		.inst_valid (inst_valid), .inst (inst), .pc (pc),
		.wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data),
		.jump_valid (jump_valid), .jump_taken (jump_taken), .jump_target (jump_target),
		.err_cnt (err_cnt), .strobe_cnt (strobe_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// half the picks stay in x0..x7 for dependencies and equal operands
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = $urandom;
		if (r[31])
			return {2'b00, r[2:0]};
		return r[4:0];
	endfunction

	function automatic logic [31:0] gen_inst();
		logic [31:0] r;
		int unsigned sel;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r   = $urandom;
		sel = $urandom_range(99, 0);
		rd  = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		f3  = r[14:12];
		if (sel < 30) begin
			f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'h20 : 7'h00; // sub, sra
			return {f7, rs2, rs1, f3, rd, OPC_OP};
		end
		if (sel < 60) begin
			if (f3 == 3'b001 || f3 == 3'b101)
				return {1'b0, r[30] && f3 == 3'b101, 5'b0, r[24:20], rs1, f3, rd, OPC_OP_IMM};
			return {r[31:20], rs1, f3, rd, OPC_OP_IMM};
		end
		if (sel < 72) begin
			if (f3[2:1] == 2'b01)
				f3[2] = 1'b1; // skip reserved branch funct3
			if (sel[0])
				rs2 = rs1;
			return {r[31:25], rs2, rs1, f3, r[11:7], OPC_BRANCH};
		end
		if (sel < 78) return {r[31:12], rd, OPC_JAL};
		if (sel < 84) return {r[31:20], rs1, 3'b000, rd, OPC_JALR};
		if (sel < 88) return {r[31:12], rd, OPC_LUI};
		if (sel < 92) return {r[31:12], rd, OPC_AUIPC};
		if (sel < 94) return {r[31:20], rs1, f3, rd, OPC_LOAD};
		if (sel < 96) return {r[31:25], rs2, rs1, f3, r[11:7], OPC_STORE};
		if (sel < 97) return {r[31:7], OPC_FENCE};
		if (sel < 98) return {r[31:7], OPC_SYS};
		return r; // mostly unknown opcodes
	endfunction

	initial begin
		int unsigned gap;
		logic [31:0] r;
		logic [31:0] cur_pc;
		void'($urandom(SEED));
		arst_n     = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		pc         = '0;
		sent       = 0;
		cur_pc     = 32'h0000_1000;
		#1 arst_n  = 1'b0; // clean falling edge
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) @(posedge clk); // idle, no pulse expected
		for (int n = 0; n < N_INST; n++) begin
			inst_valid <= 1'b1;
			inst       <= gen_inst();
			pc         <= cur_pc;
			sent++;
			@(posedge clk);
			r      = $urandom;
			cur_pc = (r[3:0] == 4'h0) ? {r[31:2], 2'b00} : cur_pc + 32'd4;
			gap    = $urandom_range(2, 0);
			if (gap != 0)
				inst_valid <= 1'b0;
			repeat (gap) @(posedge clk);
		end
		inst_valid <= 1'b0;
		repeat (4) @(posedge clk); // drain the two stages
		@(negedge clk); // last compare has settled
		$display("instructions sent %0d, seen by checker %0d, errors %0d",
			sent, strobe_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, the run timed out", TIMEOUT_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_id_opt.sv
verilog/exu_imm_gen.sv
verilog/exu_dec_stage.sv
verilog/exu_regfile.sv
verilog/exu_alu.sv
verilog/exu_wb.sv
verilog/exu_top.sv
dv/exu_checker.sv
dv/exu_tb.sv

// File: Makefile
# Verilator build and run for the RV32I execute slice

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  := *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST)) verilog/exu_cfg.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
